//--- tb.f
+incdir+.
isa_pkg.sv
regfile_pkg.sv
instr_decode.sv
operand_collector.sv
regfile_banks.sv
alu_execute.sv
result_writeback.sv
oc_top.sv
tb_oc.sv

//--- Makefile
SIM       = verilator
SIM_FLAGS = --binary --timing --assert -Wno-fatal
TOP       = tb_oc
FILELIST  = tb.f
OBJ_DIR   = obj_dir
BIN       = $(OBJ_DIR)/V$(TOP)
SOURCES   = $(filter-out +%,$(shell cat $(FILELIST))) $(wildcard *.svh)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx "RESULT: PASS"

clean:
	rm -rf $(OBJ_DIR)

//--- tb_oc.sv
`timescale 1ns/10ps
`include "gpu_defines.svh"

module tb_oc;

	localparam int WAIT_LIMIT = 200; // cycles allowed per wait loop

	logic clk;
	logic rst;
	logic instr_valid;
	logic [isa_pkg::INSTR_W-1:0] instr_word;
	logic instr_ready;
	logic wb_valid;
	isa_pkg::reg_idx_t wb_dst;
	logic [`GPU_DATA_W-1:0] wb_data;

	logic [`GPU_DATA_W-1:0] model [`GPU_NUM_REGS]; // register state in issue order
	logic [`GPU_DATA_W-1:0] exp_val [`GPU_NUM_REGS];
	int wb_pending [`GPU_NUM_REGS]; // writebacks still owed per dst
	int outstanding;
	int max_outstanding;
	int stalls; // cycles the last issue waited on instr_ready
	int seed;

	oc_top i_oc_top (
		.clk(clk), .rst(rst), .instr_valid(instr_valid), .instr_word(instr_word),
		.instr_ready(instr_ready), .wb_valid(wb_valid), .wb_dst(wb_dst), .wb_data(wb_data)
	);

	initial
	begin
		clk = 1'b0;
		forever
			#2 clk = ~clk;
	end

	task automatic stop_on_error(input string what);
		$display("%s", what);
		$display("RESULT: FAIL");
		$fatal(1, "simulation stopped at the first error");
	endtask

	// opcode, dst, src1, src2, 13 bit immediate
	function automatic logic [31:0] make_word(input isa_pkg::opcode_t op,
		input logic [4:0] dst, input logic [4:0] s1, input logic [4:0] s2,
		input logic [12:0] imm);
		return {op, dst, s1, s2, imm};
	endfunction

	function automatic logic writes_reg(input logic [31:0] w);
		return isa_pkg::opcode_t'(w[31:28]) != isa_pkg::nop;
	endfunction

	function automatic logic [31:0] expected_result(input logic [31:0] w);
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] imm;
		a = model[w[22:18]];
		b = model[w[17:13]];
		imm = {{19{w[12]}}, w[12:0]}; // sign extended
		case (isa_pkg::opcode_t'(w[31:28]))
			isa_pkg::add: return a + b;
			isa_pkg::sub: return a - b;
			isa_pkg::and_op: return a & b;
			isa_pkg::or_op: return a | b;
			isa_pkg::xor_op: return a ^ b;
			isa_pkg::addi: return a + imm;
			isa_pkg::li: return imm;
			default: return 32'h0;
		endcase
	endfunction

	// present the word, strobe valid once ready is seen
	task automatic issue(input logic [31:0] w);
		logic [4:0] dst;
		dst = w[27:23];
		@(negedge clk);
		instr_valid = 1'b0;
		instr_word = w;
		stalls = 0;
		do
		begin
			@(negedge clk);
			if (!instr_ready)
				stalls++;
			if (stalls > WAIT_LIMIT)
				stop_on_error("timeout waiting for instr_ready");
		end
		while (!instr_ready);
		instr_valid = 1'b1; // taken on the next rising edge
		if (writes_reg(w))
		begin
			exp_val[dst] = expected_result(w);
			model[dst] = exp_val[dst];
			wb_pending[dst]++;
			outstanding++;
			if (outstanding > max_outstanding)
				max_outstanding = outstanding;
		end
	endtask

	task automatic drain();
		int n;
		n = 0;
		@(negedge clk);
		instr_valid = 1'b0;
		while (outstanding != 0)
		begin
			@(negedge clk);
			n++;
			if (n > WAIT_LIMIT)
				stop_on_error("timeout waiting for outstanding writebacks");
		end
	endtask

	always @(negedge clk)
	begin
		if (!rst && wb_valid)
		begin
			a_wb_owed : assert (wb_pending[wb_dst] > 0)
			else
				stop_on_error($sformatf("writeback to r%0d with nothing in flight", wb_dst));
			a_wb_data : assert (wb_data === exp_val[wb_dst])
			else
				stop_on_error($sformatf("CHECK FAILED wb_data r%0d: expected 0x%08h, got 0x%08h",
					wb_dst, exp_val[wb_dst], wb_data));
			wb_pending[wb_dst]--;
			outstanding--;
		end
	end

	task automatic check_reset();
		int n;
		repeat (8)
		begin
			@(negedge clk);
			a_reset_quiet : assert (!wb_valid && !instr_ready)
			else
				stop_on_error("wb_valid or instr_ready high during reset");
		end
		rst = 1'b0;
		n = 0;
		while (!instr_ready)
		begin
			@(negedge clk);
			n++;
			a_no_early_wb : assert (!wb_valid)
			else
				stop_on_error("wb_valid rose with no instruction issued");
			if (n > WAIT_LIMIT)
				stop_on_error("timeout waiting for instr_ready after reset");
		end
	endtask

	task automatic load_immediates();
		logic [12:0] imm;
		for (int k = 0; k < 8; k++)
		begin
			imm = 13'($random(seed));
			if (k == 3)
				imm[12] = 1'b1; // negative value
			issue(make_word(isa_pkg::li, 5'(4 + k), 5'd0, 5'd0, imm)); // r4..r11, all banks
		end
		drain();
	endtask

	task automatic random_alu_ops();
		isa_pkg::opcode_t ops [6];
		logic [4:0] s1;
		logic [4:0] s2;
		logic [4:0] d;
		ops = '{isa_pkg::add, isa_pkg::sub, isa_pkg::and_op, isa_pkg::or_op,
			isa_pkg::xor_op, isa_pkg::addi};
		for (int k = 0; k < 6; k++)
		begin
			s1 = 5'(4 + ($unsigned($random(seed)) % 8));
			s2 = 5'(4 + ($unsigned($random(seed)) % 8));
			d = 5'(12 + ($unsigned($random(seed)) % 20));
			issue(make_word(ops[k], d, s1, s2, 13'($random(seed))));
			s2 = (s1 < 5'd8) ? s1 + 5'd4 : s1 - 5'd4; // same bank, other row
			issue(make_word(ops[k], d ^ 5'd1, s1, s2, 13'($random(seed))));
		end
		drain();
	endtask

	task automatic dependent_chain();
		issue(make_word(isa_pkg::add, 5'd20, 5'd5, 5'd6, 13'd0));
		issue(make_word(isa_pkg::addi, 5'd21, 5'd20, 5'd0, 13'h1f01));
		a_raw_stall : assert (stalls > 0)
		else
			stop_on_error("dependent instruction accepted before its producer retired");
		issue(make_word(isa_pkg::sub, 5'd21, 5'd5, 5'd4, 13'd0)); // only r21 is pending
		a_waw_stall : assert (stalls > 0)
		else
			stop_on_error("instruction accepted while its destination was pending");
		drain();
	endtask

	task automatic independent_burst();
		max_outstanding = 0;
		for (int k = 0; k < 10; k++)
		begin
			if (k == 5)
				issue(make_word(isa_pkg::nop, 5'd31, 5'd4, 5'd5, 13'd0));
			issue(make_word(k[0] ? isa_pkg::xor_op : isa_pkg::addi, 5'(12 + k),
				5'(4 + k % 8), 5'(11 - k % 8), 13'($random(seed))));
		end
		drain();
		repeat (16)
			@(negedge clk); // room for a stray writeback
		a_overlap : assert (max_outstanding >= 2)
		else
			stop_on_error("burst never had two instructions in flight");
	endtask

	initial
	begin
		seed = 44680;
		rst = 1'b1;
		instr_valid = 1'b0;
		instr_word = '0;
		outstanding = 0;
		max_outstanding = 0;
		stalls = 0;
		for (int r = 0; r < `GPU_NUM_REGS; r++)
		begin
			model[r] = '0; // banks clear on reset
			exp_val[r] = '0;
			wb_pending[r] = 0;
		end
		check_reset();
		load_immediates();
		random_alu_ops();
		dependent_chain();
		independent_burst();
		$display("RESULT: PASS");
		$finish;
	end

endmodule

//--- oc_top.sv
`timescale 1ns/10ps
`include "gpu_defines.svh"

module oc_top (
	input logic clk,
	input logic rst,
	input logic instr_valid,
	input logic [isa_pkg::INSTR_W-1:0] instr_word,
	output logic instr_ready,
	output logic wb_valid,
	output isa_pkg::reg_idx_t wb_dst,
	output logic [`GPU_DATA_W-1:0] wb_data
);

	logic [`GPU_NUM_OC-1:0] oc_free, alloc, oc_ready, take;
	isa_pkg::opcode_t dec_op;
	isa_pkg::reg_idx_t dec_dst, dec_src1, dec_src2;
	isa_pkg::imm_t dec_imm;
	logic dec_need1, dec_need2;

	// two read ports per collector
	logic [2*`GPU_NUM_OC-1:0] rd_req, rd_grant, rd_dvalid;
	regfile_pkg::bank_id_t [2*`GPU_NUM_OC-1:0] rd_bank;
	regfile_pkg::row_idx_t [2*`GPU_NUM_OC-1:0] rd_row;
	logic [2*`GPU_NUM_OC-1:0][`GPU_DATA_W-1:0] rd_data;

	isa_pkg::opcode_t oc_op [`GPU_NUM_OC];
	isa_pkg::reg_idx_t oc_dst [`GPU_NUM_OC];
	isa_pkg::imm_t oc_imm [`GPU_NUM_OC];
	logic [`GPU_DATA_W-1:0] oc_a [`GPU_NUM_OC];
	logic [`GPU_DATA_W-1:0] oc_b [`GPU_NUM_OC];

	logic res_valid;
	isa_pkg::reg_idx_t res_dst;
	logic [`GPU_DATA_W-1:0] res_data;

	instr_decode i_decode (
		.clk(clk), .rst(rst), .instr_valid(instr_valid), .instr_word(instr_word),
		.oc_free(oc_free), .wb_valid(wb_valid), .wb_dst(wb_dst),
		.instr_ready(instr_ready), .alloc(alloc), .dec_op(dec_op), .dec_dst(dec_dst),
		.dec_src1(dec_src1), .dec_src2(dec_src2), .dec_imm(dec_imm),
		.dec_need1(dec_need1), .dec_need2(dec_need2)
	);

	for (genvar i = 0; i < `GPU_NUM_OC; i++)
	begin : g_oc
		operand_collector #(.oc_id(i)) i_oc (
			.clk(clk), .rst(rst), .alloc(alloc[i]), .dec_op(dec_op), .dec_dst(dec_dst),
			.dec_src1(dec_src1), .dec_src2(dec_src2), .dec_imm(dec_imm),
			.dec_need1(dec_need1), .dec_need2(dec_need2),
			.rd_grant1(rd_grant[2*i]), .rd_grant2(rd_grant[2*i+1]),
			.rd_dvalid1(rd_dvalid[2*i]), .rd_dvalid2(rd_dvalid[2*i+1]),
			.bank_data1(rd_data[2*i]), .bank_data2(rd_data[2*i+1]), .take(take[i]),
			.oc_free(oc_free[i]), .rd_req1(rd_req[2*i]), .rd_req2(rd_req[2*i+1]),
			.rd_bank1(rd_bank[2*i]), .rd_bank2(rd_bank[2*i+1]),
			.rd_row1(rd_row[2*i]), .rd_row2(rd_row[2*i+1]), .oc_ready(oc_ready[i]),
			.oc_op(oc_op[i]), .oc_dst(oc_dst[i]), .oc_imm(oc_imm[i]),
			.oc_a(oc_a[i]), .oc_b(oc_b[i])
		);
	end

	// write port is the retiring result
	regfile_banks i_banks (
		.clk(clk), .rst(rst), .rd_req(rd_req), .rd_bank(rd_bank), .rd_row(rd_row),
		.wr_en(wb_valid), .wr_dst(wb_dst), .wr_data(wb_data),
		.rd_grant(rd_grant), .rd_dvalid(rd_dvalid), .rd_data(rd_data)
	);

	alu_execute i_exec (
		.clk(clk), .rst(rst), .oc_ready(oc_ready),
		.oc0_op(oc_op[0]), .oc1_op(oc_op[1]), .oc0_dst(oc_dst[0]), .oc1_dst(oc_dst[1]),
		.oc0_imm(oc_imm[0]), .oc1_imm(oc_imm[1]), .oc0_a(oc_a[0]), .oc0_b(oc_b[0]),
		.oc1_a(oc_a[1]), .oc1_b(oc_b[1]), .take(take),
		.res_valid(res_valid), .res_dst(res_dst), .res_data(res_data)
	);

	result_writeback i_wb (
		.clk(clk), .rst(rst), .res_valid(res_valid), .res_dst(res_dst), .res_data(res_data),
		.wb_valid(wb_valid), .wb_dst(wb_dst), .wb_data(wb_data)
	);

endmodule

//--- result_writeback.sv
`timescale 1ns/10ps
`include "gpu_defines.svh"

module result_writeback (
	input logic clk,
	input logic rst,
	input logic res_valid,
	input isa_pkg::reg_idx_t res_dst,
	input logic [`GPU_DATA_W-1:0] res_data,
	output logic wb_valid,
	output isa_pkg::reg_idx_t wb_dst,
	output logic [`GPU_DATA_W-1:0] wb_data
);

	always_ff @(posedge clk)
	begin
		if (rst)
			wb_valid <= 1'b0;
		else
			wb_valid <= res_valid;
	end

	always_ff @(posedge clk)
	begin
		wb_dst <= res_dst;
		wb_data <= res_data;
	end

	// scoreboard keeps a destination from retiring twice in a row
	a_no_repeat_dst : assert property (@(posedge clk) disable iff (rst)
		wb_valid && $past(wb_valid) |-> wb_dst != $past(wb_dst))
		else $error("back to back writeback to r%0d", wb_dst);

endmodule

//--- alu_execute.sv
`timescale 1ns/10ps
`include "gpu_defines.svh"

module alu_execute (
	input logic clk,
	input logic rst,
	input logic [`GPU_NUM_OC-1:0] oc_ready,
	input isa_pkg::opcode_t oc0_op,
	input isa_pkg::opcode_t oc1_op,
	input isa_pkg::reg_idx_t oc0_dst,
	input isa_pkg::reg_idx_t oc1_dst,
	input isa_pkg::imm_t oc0_imm,
	input isa_pkg::imm_t oc1_imm,
	input logic [`GPU_DATA_W-1:0] oc0_a,
	input logic [`GPU_DATA_W-1:0] oc0_b,
	input logic [`GPU_DATA_W-1:0] oc1_a,
	input logic [`GPU_DATA_W-1:0] oc1_b,
	output logic [`GPU_NUM_OC-1:0] take,
	output logic res_valid,
	output isa_pkg::reg_idx_t res_dst,
	output logic [`GPU_DATA_W-1:0] res_data
);

	logic rr; // set gives collector 1 the priority
	logic sel;
	isa_pkg::opcode_t op;
	isa_pkg::reg_idx_t dst;
	isa_pkg::imm_t imm;
	logic [`GPU_DATA_W-1:0] a, b, imm_ext, result;
	logic writes;

	assign sel = oc_ready[1] && (rr || !oc_ready[0]);
	assign take[1] = sel;
	assign take[0] = oc_ready[0] && !sel;

	assign op = sel ? oc1_op : oc0_op;
	assign dst = sel ? oc1_dst : oc0_dst;
	assign imm = sel ? oc1_imm : oc0_imm;
	assign a = sel ? oc1_a : oc0_a;
	assign b = sel ? oc1_b : oc0_b;
	assign imm_ext = {{(`GPU_DATA_W-isa_pkg::IMM_W){imm[isa_pkg::IMM_W-1]}}, imm};

	always_comb
	begin
		writes = 1'b1;
		case (op)
			isa_pkg::add: result = a + b;
			isa_pkg::sub: result = a - b;
			isa_pkg::and_op: result = a & b;
			isa_pkg::or_op: result = a | b;
			isa_pkg::xor_op: result = a ^ b;
			isa_pkg::addi: result = a + imm_ext;
			isa_pkg::li: result = imm_ext;
			default:
			begin
				result = '0;
				writes = 1'b0; // nop retires silently
			end
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			rr <= 1'b0;
			res_valid <= 1'b0;
		end
		else
		begin
			res_valid <= (|take) && writes;
			if (|take)
				rr <= !sel; // other side next
		end
	end

	always_ff @(posedge clk)
	begin
		res_dst <= dst;
		res_data <= result;
	end

endmodule

//--- regfile_banks.sv
`timescale 1ns/10ps
`include "gpu_defines.svh"

module regfile_banks (
	input logic clk,
	input logic rst,
	// requester order: oc0 op1, oc0 op2, oc1 op1, oc1 op2
	input logic [2*`GPU_NUM_OC-1:0] rd_req,
	input regfile_pkg::bank_id_t [2*`GPU_NUM_OC-1:0] rd_bank,
	input regfile_pkg::row_idx_t [2*`GPU_NUM_OC-1:0] rd_row,
	input logic wr_en,
	input isa_pkg::reg_idx_t wr_dst,
	input logic [`GPU_DATA_W-1:0] wr_data,
	output logic [2*`GPU_NUM_OC-1:0] rd_grant,
	output logic [2*`GPU_NUM_OC-1:0] rd_dvalid,
	output logic [2*`GPU_NUM_OC-1:0][`GPU_DATA_W-1:0] rd_data
);

	localparam int NUM_RQ = 2 * `GPU_NUM_OC;
	localparam int ROWS = `GPU_NUM_REGS / `GPU_NUM_BANKS;

	logic [`GPU_DATA_W-1:0] mem [`GPU_NUM_BANKS][ROWS];
	logic [`GPU_NUM_BANKS-1:0][NUM_RQ-1:0] bank_grant; // bank x requester
	logic [`GPU_NUM_BANKS-1:0] bank_busy;
	regfile_pkg::bank_id_t wr_bank;
	regfile_pkg::row_idx_t wr_row;

	assign wr_bank = wr_dst[1:0];
	assign wr_row = wr_dst[4:2];

	// fixed priority per bank, write port first
	always_comb
	begin
		bank_grant = '0;
		rd_grant = '0;
		for (int b = 0; b < `GPU_NUM_BANKS; b++)
		begin
			bank_busy[b] = wr_en && wr_bank == b;
			for (int r = 0; r < NUM_RQ; r++)
			begin
				if (rd_req[r] && rd_bank[r] == b && !bank_busy[b])
				begin
					bank_grant[b][r] = 1'b1;
					bank_busy[b] = 1'b1;
				end
			end
			rd_grant = rd_grant | bank_grant[b];
		end
	end

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			rd_dvalid <= '0;
			for (int b = 0; b < `GPU_NUM_BANKS; b++)
				for (int w = 0; w < ROWS; w++)
					mem[b][w] <= '0;
		end
		else
		begin
			rd_dvalid <= rd_grant; // data follows grant by one cycle
			if (wr_en)
				mem[wr_bank][wr_row] <= wr_data;
		end
	end

	always_ff @(posedge clk)
	begin
		for (int r = 0; r < NUM_RQ; r++)
			if (rd_grant[r])
				rd_data[r] <= mem[rd_bank[r]][rd_row[r]];
	end

	// single port: one access per bank per cycle, write included
	for (genvar b = 0; b < `GPU_NUM_BANKS; b++)
	begin : g_port_chk
		a_one_access : assert property (@(posedge clk) disable iff (rst)
			$onehot0({bank_grant[b], wr_en && wr_bank == b}))
			else $error("bank %0d accessed twice in one cycle", b);
	end

endmodule

//--- operand_collector.sv
`timescale 1ns/10ps
`include "gpu_defines.svh"

module operand_collector #(
	parameter int oc_id = 0
) (
	input logic clk,
	input logic rst,
	input logic alloc,
	input isa_pkg::opcode_t dec_op,
	input isa_pkg::reg_idx_t dec_dst,
	input isa_pkg::reg_idx_t dec_src1,
	input isa_pkg::reg_idx_t dec_src2,
	input isa_pkg::imm_t dec_imm,
	input logic dec_need1,
	input logic dec_need2,
	input logic rd_grant1,
	input logic rd_grant2,
	input logic rd_dvalid1,
	input logic rd_dvalid2,
	input logic [`GPU_DATA_W-1:0] bank_data1,
	input logic [`GPU_DATA_W-1:0] bank_data2,
	input logic take,
	output logic oc_free,
	output logic rd_req1,
	output logic rd_req2,
	output regfile_pkg::bank_id_t rd_bank1,
	output regfile_pkg::bank_id_t rd_bank2,
	output regfile_pkg::row_idx_t rd_row1,
	output regfile_pkg::row_idx_t rd_row2,
	output logic oc_ready,
	output isa_pkg::opcode_t oc_op,
	output isa_pkg::reg_idx_t oc_dst,
	output isa_pkg::imm_t oc_imm,
	output logic [`GPU_DATA_W-1:0] oc_a,
	output logic [`GPU_DATA_W-1:0] oc_b
);

	regfile_pkg::oc_state_t state;
	logic need1, need2; // operand is used by the opcode
	logic sent1, sent2; // bank read granted
	logic got1, got2; // operand captured
	logic done1, done2;

	assign oc_free = (state == regfile_pkg::free);
	assign oc_ready = (state == regfile_pkg::ready);
	assign rd_req1 = (state == regfile_pkg::collecting) && need1 && !sent1;
	assign rd_req2 = (state == regfile_pkg::collecting) && need2 && !sent2;

	// in hand by the next edge
	assign done1 = !need1 || got1 || rd_dvalid1;
	assign done2 = !need2 || got2 || rd_dvalid2;

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			state <= regfile_pkg::free;
			need1 <= 1'b0;
			need2 <= 1'b0;
			sent1 <= 1'b0;
			sent2 <= 1'b0;
			got1 <= 1'b0;
			got2 <= 1'b0;
		end
		else
		begin
			case (state)
				regfile_pkg::free:
					if (alloc)
					begin
						need1 <= dec_need1;
						need2 <= dec_need2;
						sent1 <= 1'b0;
						sent2 <= 1'b0;
						got1 <= 1'b0;
						got2 <= 1'b0;
						// li and nop have nothing to fetch
						state <= (dec_need1 || dec_need2) ? regfile_pkg::collecting : regfile_pkg::ready;
					end
				regfile_pkg::collecting:
				begin
					if (rd_grant1)
						sent1 <= 1'b1;
					if (rd_grant2)
						sent2 <= 1'b1;
					if (rd_dvalid1)
						got1 <= 1'b1;
					if (rd_dvalid2)
						got2 <= 1'b1;
					if (done1 && done2)
						state <= regfile_pkg::ready;
				end
				regfile_pkg::ready:
					if (take)
						state <= regfile_pkg::free;
				default: state <= regfile_pkg::free;
			endcase
		end
	end

	always_ff @(posedge clk)
	begin
		if (alloc && oc_free)
		begin
			oc_op <= dec_op;
			oc_dst <= dec_dst;
			oc_imm <= dec_imm;
			rd_bank1 <= dec_src1[1:0]; // bank = reg % 4
			rd_row1 <= dec_src1[4:2];
			rd_bank2 <= dec_src2[1:0];
			rd_row2 <= dec_src2[4:2];
		end
		if (rd_dvalid1)
			oc_a <= bank_data1;
		if (rd_dvalid2)
			oc_b <= bank_data2;
	end

	a_take_ready : assert property (@(posedge clk) disable iff (rst)
		take |-> oc_ready ##1 oc_free)
		else $error("collector %0d taken while not ready", oc_id);

endmodule

//--- instr_decode.sv
`timescale 1ns/10ps
`include "gpu_defines.svh"

module instr_decode (
	input logic clk,
	input logic rst,
	input logic instr_valid,
	input logic [isa_pkg::INSTR_W-1:0] instr_word,
	input logic [`GPU_NUM_OC-1:0] oc_free,
	input logic wb_valid,
	input isa_pkg::reg_idx_t wb_dst,
	output logic instr_ready,
	output logic [`GPU_NUM_OC-1:0] alloc,
	output isa_pkg::opcode_t dec_op,
	output isa_pkg::reg_idx_t dec_dst,
	output isa_pkg::reg_idx_t dec_src1,
	output isa_pkg::reg_idx_t dec_src2,
	output isa_pkg::imm_t dec_imm,
	output logic dec_need1,
	output logic dec_need2
);

	logic [`GPU_NUM_REGS-1:0] pending; // one bit per dst in flight
	logic ready_en;
	logic writes_dst;
	logic hazard;
	logic accept;
	logic taken;

	assign dec_op = isa_pkg::opcode_t'(instr_word[isa_pkg::OPC_LSB +: isa_pkg::OPC_W]);
	assign dec_dst = instr_word[isa_pkg::DST_LSB +: isa_pkg::REG_W];
	assign dec_src1 = instr_word[isa_pkg::SRC1_LSB +: isa_pkg::REG_W];
	assign dec_src2 = instr_word[isa_pkg::SRC2_LSB +: isa_pkg::REG_W];
	assign dec_imm = {{(isa_pkg::IMM_W-isa_pkg::IMM_FIELD_W){instr_word[isa_pkg::IMM_FIELD_W-1]}},
		instr_word[isa_pkg::IMM_FIELD_W-1:0]};

	always_comb
	begin
		dec_need1 = 1'b0;
		dec_need2 = 1'b0;
		writes_dst = 1'b1;
		case (dec_op)
			isa_pkg::add, isa_pkg::sub, isa_pkg::and_op, isa_pkg::or_op, isa_pkg::xor_op:
			begin
				dec_need1 = 1'b1;
				dec_need2 = 1'b1;
			end
			isa_pkg::addi: dec_need1 = 1'b1;
			isa_pkg::li: writes_dst = 1'b1; // immediate only
			default: writes_dst = 1'b0; // nop and unused codes
		endcase
	end

	assign hazard = (dec_need1 && pending[dec_src1]) || (dec_need2 && pending[dec_src2]) ||
		(writes_dst && pending[dec_dst]);
	assign instr_ready = ready_en && (|oc_free) && !hazard;
	assign accept = instr_valid && instr_ready;

	// lowest numbered free collector wins
	always_comb
	begin
		taken = 1'b0;
		for (int i = 0; i < `GPU_NUM_OC; i++)
		begin
			alloc[i] = accept && oc_free[i] && !taken;
			taken = taken || oc_free[i];
		end
	end

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			pending <= '0;
			ready_en <= 1'b0;
		end
		else
		begin
			ready_en <= 1'b1;
			for (int r = 0; r < `GPU_NUM_REGS; r++)
			begin
				if (accept && writes_dst && dec_dst == r)
					pending[r] <= 1'b1;
				else if (wb_valid && wb_dst == r)
					pending[r] <= 1'b0; // result has retired
			end
		end
	end

	// a collector picked here must leave its free state on the next cycle
	for (genvar i = 0; i < `GPU_NUM_OC; i++)
	begin : g_alloc_chk
		a_alloc_free : assert property (@(posedge clk) disable iff (rst)
			alloc[i] |-> oc_free[i] ##1 !oc_free[i])
			else $error("alloc to collector %0d that was not free", i);
	end

endmodule

//--- regfile_pkg.sv
`include "gpu_defines.svh"

package regfile_pkg;

	typedef enum logic [1:0] {
		free = 2'd0,
		collecting = 2'd1,
		ready = 2'd2
	} oc_state_t;

	typedef logic [$clog2(`GPU_NUM_BANKS)-1:0] bank_id_t;
	typedef logic [$clog2(`GPU_NUM_REGS/`GPU_NUM_BANKS)-1:0] row_idx_t;

endpackage

//--- isa_pkg.sv
package isa_pkg;

	localparam int INSTR_W = 32;
	localparam int OPC_W = 4;
	localparam int REG_W = 5;
	localparam int IMM_FIELD_W = 13; // raw immediate in the word
	localparam int IMM_W = 16;

	// field positions, top down
	localparam int OPC_LSB = 28;
	localparam int DST_LSB = 23;
	localparam int SRC1_LSB = 18;
	localparam int SRC2_LSB = 13;

	typedef enum logic [OPC_W-1:0] {
		nop = 4'd0,
		add = 4'd1,
		sub = 4'd2,
		and_op = 4'd3,
		or_op = 4'd4,
		xor_op = 4'd5,
		addi = 4'd6,
		li = 4'd7
	} opcode_t;

	typedef logic [REG_W-1:0] reg_idx_t;
	typedef logic [IMM_W-1:0] imm_t;

endpackage

//--- gpu_defines.svh
`ifndef GPU_DEFINES_SVH
`define GPU_DEFINES_SVH

// datapath width of one lane
`define GPU_DATA_W 32

// architectural registers r0..r31
`define GPU_NUM_REGS 32

// single-ported banks, bank = reg % 4, row = reg / 4
`define GPU_NUM_BANKS 4

// operand collector units
`define GPU_NUM_OC 2

`endif
